//--- Bender.yml
package:
  name: aes_pim

sources:
  - files:
      - verilog/aes_pim_pkg.sv
      - verilog/round_sequencer.sv
      - verilog/plane_gather.sv
      - verilog/array_driver.sv
      - verilog/round_state.sv
      - verilog/aes_pim_top.sv
  - target: simulation
    files:
      - verif/pim_array_model.sv
      - verif/aes_pim_asserts.sv
      - verif/aes_pim_tb.sv

//--- aes_pim.f
verilog/aes_pim_pkg.sv
verilog/round_sequencer.sv
verilog/plane_gather.sv
verilog/array_driver.sv
verilog/round_state.sv
verilog/aes_pim_top.sv
verif/pim_array_model.sv
verif/aes_pim_asserts.sv
verif/aes_pim_tb.sv

//--- verif/aes_pim_asserts.sv
// protocol checks on the top level ports; fail_count is read by the testbench at the end
`timescale 1ns/10ps

module aes_pim_asserts (
    input logic                    CLK,
    input logic                    rst,
    input logic                    busy,
    input logic                    data_valid,
    input aes_pim_pkg::array_req_t array_req,
    input aes_pim_pkg::array_rsp_t array_rsp
);

    int fail_count = 0;

    logic req_open;
    logic [$bits(aes_pim_pkg::array_req_t)-2:0] req_body;

    // everything in the request except the pulse itself
    assign req_body = {array_req.plane_read, array_req.in_slice, array_req.addr};

    // open from the cycle after io_en up to the rd_done cycle
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            req_open <= 1'b0;
        end else if (array_req.io_en) begin
            req_open <= 1'b1;
        end else if (array_rsp.rd_done) begin
            req_open <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // properties
    // ------------------------------------------------------------
    io_en_single: assert property (@(posedge CLK) disable iff (rst)
        array_req.io_en |=> !array_req.io_en)
        else begin
            fail_count++;
            $error("io_en stayed high for more than one cycle");
        end

    req_stable: assert property (@(posedge CLK) disable iff (rst)
        req_open |-> $stable(req_body))
        else begin
            fail_count++;
            $error("array request changed while a request was open");
        end

    no_idle_req: assert property (@(posedge CLK) disable iff (rst)
        array_req.io_en |-> busy)
        else begin
            fail_count++;
            $error("io_en raised while the controller was idle");
        end

    valid_at_end: assert property (@(posedge CLK) disable iff (rst)
        data_valid |-> (!busy && $past(busy)))
        else begin
            fail_count++;
            $error("data_valid high without busy falling");
        end

endmodule

bind aes_pim_top aes_pim_asserts asserts_i (.*);

//--- verif/aes_pim_tb.sv
// four blocks with random array delays; needs the bound protocol checker inside uut
`timescale 1ns/10ps

module aes_pim_tb;

    localparam int TIMEOUT_CYCLES = 2500;

    logic                    CLK = 1'b0;
    logic                    rst;
    logic                    kd_rdy;
    logic [127:0]            din;
    logic                    busy;
    logic                    data_valid;
    logic [127:0]            dout;
    aes_pim_pkg::array_req_t array_req;
    aes_pim_pkg::array_rsp_t array_rsp;

    int    errors    = 0;
    int    cycles    = 0;
    int    req_count = 0;
    int    dv_count  = 0;
    string test_name = "reset";

    aes_pim_top uut (
        .CLK        (CLK),
        .rst        (rst),
        .kd_rdy     (kd_rdy),
        .din        (din),
        .array_rsp  (array_rsp),
        .busy       (busy),
        .data_valid (data_valid),
        .dout       (dout),
        .array_req  (array_req)
    );

    pim_array_model array_i (
        .CLK       (CLK),
        .rst       (rst),
        .array_req (array_req),
        .array_rsp (array_rsp)
    );

    always #50 CLK = ~CLK;

    // ------------------------------------------------------------
    // expected result, 11 groups of gather then lookup
    // ------------------------------------------------------------
    function automatic logic [127:0] predict(input logic [127:0] blk);
        logic [127:0] st;
        logic [127:0] res;
        logic [7:0]   ark [16];
        logic [7:0]   rep [16];
        logic [7:0]   grp_byte;
        st = blk;
        for (int g = 0; g <= 10; g++) begin
            grp_byte = {6'(g / 4), 2'(3 - g % 4)};
            for (int k = 0; k < 8; k++) begin
                for (int i = 0; i < 16; i++) begin
                    rep[i] = grp_byte ^ {4'(i), 4'h0} ^ st[127-16*k -: 8];
                end
                for (int j = 0; j < 8; j++) begin
                    ark[2*k][j]   = rep[j][7-k];
                    ark[2*k+1][j] = rep[j+8][7-k];
                end
            end
            // lookup reply is the ark byte rotated left by two
            for (int i = 0; i < 16; i++) begin
                st[127-8*i -: 8] = {ark[i][5:0], ark[i][7:6]} ^ {4'(i), 4'h0};
                res[127-8*i -: 8] = ark[i];
            end
        end
        return res;
    endfunction

    // request monitor, mid-cycle
    always @(negedge CLK) begin
        logic [8:0] exp_addr;
        int grp;
        grp      = req_count / 9;
        exp_addr = {3'(7 - grp % 4), 6'(grp / 4)};
        if (array_req.io_en) begin
            assert (array_req.plane_read == ((req_count % 9) < 8)) else begin
                errors++;
                $display("Fail %s plane_read of request %0d: expected %b, actual %b",
                         test_name, req_count, (req_count % 9) < 8, array_req.plane_read);
            end
            for (int i = 0; i < 16; i++) begin
                assert (!array_req.plane_read || array_req.addr[i] == exp_addr) else begin
                    errors++;
                    $display("Fail %s read addr of request %0d lane %0d: expected %h, actual %h",
                             test_name, req_count, i, exp_addr, array_req.addr[i]);
                end
            end
            req_count++;
        end
        if (data_valid) begin
            dv_count++;
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic run_block(input string name, input logic [127:0] blk, input bit poke);
        logic [127:0] exp;
        exp = predict(blk);
        @(negedge CLK);
        test_name = name;
        req_count = 0;
        dv_count  = 0;
        din       = blk;
        kd_rdy    = 1'b1;
        @(negedge CLK);
        kd_rdy = 1'b0;
        din    = ~blk;
        if (poke) begin
            repeat (20) @(negedge CLK);
            kd_rdy = 1'b1;
            @(negedge CLK);
            kd_rdy = 1'b0;
        end
        while (!data_valid) begin
            @(negedge CLK);
        end
        assert (dout == exp) else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, dout);
        end
        @(negedge CLK);
        assert (!data_valid && dv_count == 1 && req_count == 99) else begin
            errors++;
            $display("Fail %s: expected 1 data_valid pulse and 99 requests, actual %0d and %0d",
                     name, dv_count, req_count);
        end
    endtask

    initial begin
        rst    = 1'b1;
        kd_rdy = 1'b0;
        din    = '0;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        assert (!busy && !data_valid && !array_req.io_en && !array_req.plane_read
                && dout == '0) else begin
            errors++;
            $display("Fail reset: expected all zero, actual busy %b data_valid %b io_en %b",
                     busy, data_valid, array_req.io_en);
            $display("Fail reset: expected all zero, actual plane_read %b dout %h",
                     array_req.plane_read, dout);
        end
        rst = 1'b0;
        run_block("single", 128'h3243f6a8885a308d313198a2e0370734, 1'b0);
        run_block("kd_rdy while busy", 128'h00112233445566778899aabbccddeeff, 1'b1);
        run_block("back to back a", 128'h0123456789abcdeffedcba9876543210, 1'b0);
        run_block("back to back b", 128'hffffffff00000000a5a5a5a55a5a5a5a, 1'b0);
        $display("errors: %0d testbench, %0d protocol", errors, uut.asserts_i.fail_count);
        if (errors == 0 && uut.asserts_i.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verif/pim_array_model.sv
// behavioral array; answers each io_en after 1 to 4 cycles and holds the request as stable
`timescale 1ns/10ps

module pim_array_model (
    input  logic                    CLK,
    input  logic                    rst,
    input  aes_pim_pkg::array_req_t array_req,
    output aes_pim_pkg::array_rsp_t array_rsp
);

    logic [15:0] lfsr;
    logic [2:0]  wait_cnt;

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // row, then low demux bits, mixed with lane index and slice
    function automatic logic [7:0] lane_reply(input aes_pim_pkg::array_req_t req,
                                              input int lane);
        logic [7:0] base;
        base = {req.addr[lane].row, req.addr[lane].demux[1:0]};
        return base ^ {4'(lane), 4'h0} ^ req.in_slice[15:8];
    endfunction

    // ------------------------------------------------------------
    // request handling, driven on the falling edge
    // ------------------------------------------------------------
    always @(negedge CLK or posedge rst) begin
        logic [15:0] s1;
        logic [15:0] s2;
        if (rst) begin
            lfsr      <= 16'd19225;
            wait_cnt  <= 3'd0;
            array_rsp <= '0;
        end else begin
            array_rsp.rd_done <= 1'b0;
            if (array_req.io_en) begin
                // two lfsr steps, one bit each
                s1       = lfsr_step(lfsr);
                s2       = lfsr_step(s1);
                lfsr     <= s2;
                wait_cnt <= {1'b0, s2[0], s1[0]} + 3'd1;
            end else if (wait_cnt == 3'd1) begin
                wait_cnt          <= 3'd0;
                array_rsp.rd_done <= 1'b1;
                for (int i = 0; i < aes_pim_pkg::NUM_LANES; i++) begin
                    array_rsp.rio[i] <= lane_reply(array_req, i);
                end
            end else if (wait_cnt != 3'd0) begin
                wait_cnt <= wait_cnt - 3'd1;
            end
        end
    end

endmodule

//--- verilog/aes_pim_pkg.sv
// shared types for the pim round controller; lane 0 is always the most significant byte
package aes_pim_pkg;

    // ------------------------------------------------------------
    // array geometry and round count
    // ------------------------------------------------------------
    localparam int NUM_LANES  = 16;
    localparam int NUM_PLANES = 8;
    localparam int LAST_GROUP = 10;
    localparam int SLICE_W    = 16;
    localparam int BLOCK_W    = 128;
    localparam int DEMUX_W    = 3;
    localparam int ROW_W      = 6;

    // one lane address as seen by the array decoders
    typedef struct packed {
        logic [DEMUX_W-1:0] demux;
        logic [ROW_W-1:0]   row;
    } lane_addr_t;

    // lookup view of an add-round-key byte
    typedef struct packed {
        logic [1:0]       col;
        logic [ROW_W-1:0] row;
    } lut_addr_t;

    typedef union packed {
        logic [7:0] data;
        lut_addr_t  addr;
    } lane_byte_u;

    typedef lane_byte_u [0:NUM_LANES-1] lane_bytes_t;

    // ------------------------------------------------------------
    // array request and response
    // ------------------------------------------------------------
    typedef struct packed {
        logic                       io_en;
        logic                       plane_read;
        logic [SLICE_W-1:0]         in_slice;
        lane_addr_t [0:NUM_LANES-1] addr;
    } array_req_t;

    typedef struct packed {
        logic                      rd_done;
        logic [0:NUM_LANES-1][7:0] rio;
    } array_rsp_t;

    typedef enum logic [1:0] {IDLE, READ, LOOKUP, MIX} phase_t;

endpackage

//--- verilog/aes_pim_top.sv
// always enabled; kd_rdy is ignored while busy, and the array must hold rio valid with rd_done
`timescale 1ns/10ps

module aes_pim_top (
    input  logic                             CLK,
    input  logic                             rst,
    input  logic                             kd_rdy,
    input  logic [aes_pim_pkg::BLOCK_W-1:0]  din,
    input  aes_pim_pkg::array_rsp_t          array_rsp,
    output logic                             busy,
    output logic                             data_valid,
    output logic [aes_pim_pkg::BLOCK_W-1:0]  dout,
    output aes_pim_pkg::array_req_t          array_req
);

    // ------------------------------------------------------------
    // sequencer to datapath
    // ------------------------------------------------------------
    aes_pim_pkg::phase_t             phase;
    logic [3:0]                      grp_idx;
    logic [2:0]                      read_idx;
    logic                            load;
    logic                            plane_capture;
    logic                            mix_capture;
    logic                            out_capture;
    logic                            io_en;

    // datapath registers
    logic [aes_pim_pkg::BLOCK_W-1:0] state;
    aes_pim_pkg::lane_bytes_t        ark;

    round_sequencer round_sequencer_i (
        .CLK           (CLK),
        .rst           (rst),
        .kd_rdy        (kd_rdy),
        .rd_done       (array_rsp.rd_done),
        .phase         (phase),
        .grp_idx       (grp_idx),
        .read_idx      (read_idx),
        .load          (load),
        .plane_capture (plane_capture),
        .mix_capture   (mix_capture),
        .out_capture   (out_capture),
        .io_en         (io_en),
        .busy          (busy),
        .data_valid    (data_valid)
    );

    plane_gather plane_gather_i (
        .CLK           (CLK),
        .rst           (rst),
        .load          (load),
        .plane_capture (plane_capture),
        .read_idx      (read_idx),
        .rio           (array_rsp.rio),
        .ark           (ark)
    );

    array_driver array_driver_i (
        .phase     (phase),
        .grp_idx   (grp_idx),
        .read_idx  (read_idx),
        .io_en     (io_en),
        .state     (state),
        .ark       (ark),
        .array_req (array_req)
    );

    round_state round_state_i (
        .CLK         (CLK),
        .rst         (rst),
        .load        (load),
        .din         (din),
        .mix_capture (mix_capture),
        .out_capture (out_capture),
        .rio         (array_rsp.rio),
        .ark         (ark),
        .state       (state),
        .dout        (dout)
    );

endmodule

//--- verilog/array_driver.sv
// purely combinational; all request fields are zero outside the READ and LOOKUP phases
`timescale 1ns/10ps

module array_driver (
    input  aes_pim_pkg::phase_t                phase,
    input  logic [3:0]                         grp_idx,
    input  logic [2:0]                         read_idx,
    input  logic                               io_en,
    input  logic [aes_pim_pkg::BLOCK_W-1:0]    state,
    input  aes_pim_pkg::lane_bytes_t           ark,
    output aes_pim_pkg::array_req_t            array_req
);

    // state as eight slices, slice 0 at the top
    logic [0:aes_pim_pkg::NUM_PLANES-1][aes_pim_pkg::SLICE_W-1:0] slices;
    aes_pim_pkg::lane_addr_t grp_addr;

    assign slices = state;

    // ------------------------------------------------------------
    // group table: demux steps down 7..4, row steps every 4 groups
    // ------------------------------------------------------------
    assign grp_addr.demux = 3'd7 - {1'b0, grp_idx[1:0]};
    assign grp_addr.row   = {4'd0, grp_idx[3:2]};

    always_comb begin
        array_req = '0;
        case (phase)
            aes_pim_pkg::READ: begin
                array_req.io_en      = io_en;
                array_req.plane_read = 1'b1;
                array_req.in_slice   = slices[read_idx];
                for (int i = 0; i < aes_pim_pkg::NUM_LANES; i++) begin
                    array_req.addr[i] = grp_addr;
                end
            end
            aes_pim_pkg::LOOKUP: begin
                array_req.io_en = io_en;
                // each ark byte is its own lane address
                for (int i = 0; i < aes_pim_pkg::NUM_LANES; i++) begin
                    array_req.addr[i].demux = {1'b0, ark[i].addr.col};
                    array_req.addr[i].row   = ark[i].addr.row;
                end
            end
            default: begin
                array_req = '0;
            end
        endcase
    end

endmodule

//--- verilog/plane_gather.sv
// read k fills ark bytes 2k and 2k+1 from bit 7-k of each lane; bytes hold until the next load
`timescale 1ns/10ps

module plane_gather (
    input  logic                                 CLK,
    input  logic                                 rst,
    input  logic                                 load,
    input  logic                                 plane_capture,
    input  logic [2:0]                           read_idx,
    input  logic [0:aes_pim_pkg::NUM_LANES-1][7:0] rio,
    output aes_pim_pkg::lane_bytes_t             ark
);

    localparam int HALF = aes_pim_pkg::NUM_LANES / 2;

    logic [2:0] bit_sel;
    logic [7:0] lo_byte;
    logic [7:0] hi_byte;

    // plane k carries bit 7-k of every lane
    assign bit_sel = 3'd7 - read_idx;

    // ------------------------------------------------------------
    // transpose one plane, lane j of each half lands in bit j
    // ------------------------------------------------------------
    always_comb begin
        for (int j = 0; j < HALF; j++) begin
            lo_byte[j] = rio[j][bit_sel];
            hi_byte[j] = rio[j + HALF][bit_sel];
        end
    end

    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            ark <= '0;
        end else if (load) begin
            ark <= '0;
        end else if (plane_capture) begin
            ark[{read_idx, 1'b0}].data <= lo_byte;
            ark[{read_idx, 1'b1}].data <= hi_byte;
        end
    end

endmodule

//--- verilog/round_sequencer.sv
// one block at a time; rd_done is only honoured in READ and LOOKUP, and must follow io_en
`timescale 1ns/10ps

module round_sequencer (
    input  logic                CLK,
    input  logic                rst,
    input  logic                kd_rdy,
    input  logic                rd_done,
    output aes_pim_pkg::phase_t phase,
    output logic [3:0]          grp_idx,
    output logic [2:0]          read_idx,
    output logic                load,
    output logic                plane_capture,
    output logic                mix_capture,
    output logic                out_capture,
    output logic                io_en,
    output logic                busy,
    output logic                data_valid
);

    logic last_read;
    logic last_group;

    assign last_read  = (read_idx == 3'(aes_pim_pkg::NUM_PLANES - 1));
    assign last_group = (grp_idx == 4'(aes_pim_pkg::LAST_GROUP));

    // ------------------------------------------------------------
    // capture strobes, all taken at the rd_done edge
    // ------------------------------------------------------------
    assign load          = (phase == aes_pim_pkg::IDLE) && kd_rdy;
    assign plane_capture = (phase == aes_pim_pkg::READ) && rd_done;
    // lookup result becomes next state, or the ark bytes become the output
    assign mix_capture   = (phase == aes_pim_pkg::LOOKUP) && rd_done && !last_group;
    assign out_capture   = (phase == aes_pim_pkg::LOOKUP) && rd_done && last_group;

    // ------------------------------------------------------------
    // phase walk and request pulses
    // ------------------------------------------------------------
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            phase      <= aes_pim_pkg::IDLE;
            grp_idx    <= 4'd0;
            read_idx   <= 3'd0;
            io_en      <= 1'b0;
            busy       <= 1'b0;
            data_valid <= 1'b0;
        end else begin
            // io_en is a single cycle pulse unless set below
            io_en      <= 1'b0;
            data_valid <= out_capture;
            case (phase)
                aes_pim_pkg::IDLE: begin
                    if (kd_rdy) begin
                        phase    <= aes_pim_pkg::READ;
                        grp_idx  <= 4'd0;
                        read_idx <= 3'd0;
                        io_en    <= 1'b1;
                        busy     <= 1'b1;
                    end
                end
                aes_pim_pkg::READ: begin
                    if (rd_done) begin
                        // wraps to 0 after the eighth plane
                        read_idx <= read_idx + 3'd1;
                        io_en    <= 1'b1;
                        if (last_read) begin
                            phase <= aes_pim_pkg::LOOKUP;
                        end
                    end
                end
                aes_pim_pkg::LOOKUP: begin
                    if (rd_done) begin
                        if (last_group) begin
                            phase <= aes_pim_pkg::IDLE;
                            busy  <= 1'b0;
                        end else begin
                            phase   <= aes_pim_pkg::MIX;
                            grp_idx <= grp_idx + 4'd1;
                        end
                    end
                end
                aes_pim_pkg::MIX: begin
                    // state already holds the mixed bytes, start next group
                    phase <= aes_pim_pkg::READ;
                    io_en <= 1'b1;
                end
                default: begin
                    phase <= aes_pim_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

//--- verilog/round_state.sv
// state is only meaningful after a load; dout changes only on the last group's lookup done
`timescale 1ns/10ps

module round_state (
    input  logic                                   CLK,
    input  logic                                   rst,
    input  logic                                   load,
    input  logic [aes_pim_pkg::BLOCK_W-1:0]        din,
    input  logic                                   mix_capture,
    input  logic                                   out_capture,
    input  logic [0:aes_pim_pkg::NUM_LANES-1][7:0] rio,
    input  aes_pim_pkg::lane_bytes_t               ark,
    output logic [aes_pim_pkg::BLOCK_W-1:0]        state,
    output logic [aes_pim_pkg::BLOCK_W-1:0]        dout
);

    logic [aes_pim_pkg::BLOCK_W-1:0] ark_data;

    // byte 0 goes to the top of the output block
    always_comb begin
        for (int i = 0; i < aes_pim_pkg::NUM_LANES; i++) begin
            ark_data[aes_pim_pkg::BLOCK_W-1-8*i -: 8] = ark[i].data;
        end
    end

    // ------------------------------------------------------------
    // round state, lane 0 of rio in the top byte
    // ------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (load) begin
            state <= din;
        end else if (mix_capture) begin
            state <= rio;
        end
    end

    // ------------------------------------------------------------
    // output block
    // ------------------------------------------------------------
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            dout <= '0;
        end else if (out_capture) begin
            dout <= ark_data;
        end
    end

endmodule
